// ==== common/tinyqv_config.svh ====
`ifndef TINYQV_CONFIG_SVH
`define TINYQV_CONFIG_SVH

// Architectural register count
// x0 is hardwired to zero and has no storage
`define TQV_NUM_REGS 16

// Register index width for TQV_NUM_REGS registers
`define TQV_REG_ADDR_BITS 4

`endif

// ==== common/tinyqv_pkg.sv ====
package tinyqv_pkg;

    // ALU operation encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ALU_ADD = 4'b0000,
        ALU_SLT = 4'b0010,
        ALU_XOR = 4'b0100,
        ALU_OR  = 4'b0110,
        ALU_AND = 4'b0111,
        ALU_SUB = 4'b1000
    } alu_op_t;

    // Store width in the data_write_n code
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10,
        MEM_NONE = 2'b11
    } mem_width_t;

    // Major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    // One slice of the serial datapath
    typedef logic [3:0] nibble_t;

endpackage

// ==== core/tinyqv_core.sv ====
`timescale 1ns/10ps
`include "tinyqv_config.svh"

module tinyqv_core (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [3:0]                    imm,
    input  logic                          is_alu_imm,
    input  logic                          is_alu_reg,
    input  logic                          is_lui,
    input  logic                          is_store,
    input  logic                          is_stall,
    input  tinyqv_pkg::alu_op_t           alu_op,
    input  logic [`TQV_REG_ADDR_BITS-1:0] rs1,
    input  logic [`TQV_REG_ADDR_BITS-1:0] rs2,
    input  logic [`TQV_REG_ADDR_BITS-1:0] rd,
    input  logic [2:0]                    counter,
    output logic [3:0]                    data_out,
    output logic [27:0]                   addr_out,
    output logic                          address_ready,
    output logic                          instr_complete
);
    import tinyqv_pkg::*;

    logic [`TQV_NUM_REGS*4-1:0] reg_nibbles;
    nibble_t     rs1_data;
    nibble_t     rs2_data;
    nibble_t     alu_b;
    nibble_t     alu_result;
    nibble_t     rd_data;
    logic        is_slt;
    logic        slt_second;
    logic        writes_rd;
    logic        reg_wen;
    logic [27:0] addr_shift;

    assign alu_b = is_alu_reg ? rs2_data : imm;

    tinyqv_alu i_alu (
        .clk     (clk),
        .op      (alu_op),
        .a       (rs1_data),
        .b       (alu_b),
        .counter (counter),
        .result  (alu_result)
    );

    assign is_slt    = (is_alu_imm || is_alu_reg) && (alu_op == ALU_SLT);
    assign writes_rd = is_alu_imm || is_alu_reg || is_lui;

    // Second SLT round only drops the result bit into nibble 0
    assign reg_wen = writes_rd && !is_stall && (!slt_second || counter == 3'd0);
    assign rd_data = is_lui ? imm : alu_result;

    assign reg_nibbles[3:0] = 4'h0;  // x0

    genvar i;
    generate
        for (i = 1; i < `TQV_NUM_REGS; i++) begin : g_reg
            localparam logic [`TQV_REG_ADDR_BITS-1:0] IDX = i;

            tinyqv_register i_reg (
                .clk      (clk),
                .wen      (reg_wen && rd == IDX),
                .data_in  (rd_data),
                .data_out (reg_nibbles[i*4 +: 4])
            );
        end
    endgenerate

    tinyqv_reg_read i_reg_read (
        .reg_nibbles (reg_nibbles),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            slt_second <= 1'b0;
        end else if (counter == 3'd7 && !is_stall) begin
            slt_second <= is_slt && !slt_second;
        end
    end

    // Nibbles 0..6 of the sum form the 28-bit address
    always_ff @(posedge clk) begin
        if (counter != 3'd7) begin
            addr_shift <= {alu_result, addr_shift[27:4]};
        end
    end

    assign addr_out       = addr_shift;
    assign address_ready  = is_store && !is_stall && (counter == 3'd7);
    assign data_out       = rs2_data;  // Store data streams straight from rs2
    assign instr_complete = (counter == 3'd7) && !is_stall && !(is_slt && !slt_second);

endmodule

// ==== core/tinyqv_reg_read.sv ====
`timescale 1ns/10ps
`include "tinyqv_config.svh"

module tinyqv_reg_read (
    input  logic [`TQV_NUM_REGS*4-1:0]    reg_nibbles,
    input  logic [`TQV_REG_ADDR_BITS-1:0] rs1,
    input  logic [`TQV_REG_ADDR_BITS-1:0] rs2,
    output logic [3:0]                    rs1_data,
    output logic [3:0]                    rs2_data
);
    import tinyqv_pkg::*;

    nibble_t rs1_sel;
    nibble_t rs2_sel;

    // Loop starts at 1 so x0 falls through to zero
    always_comb begin
        rs1_sel = 4'h0;
        rs2_sel = 4'h0;
        for (int i = 1; i < `TQV_NUM_REGS; i++) begin
            if (rs1 == i[`TQV_REG_ADDR_BITS-1:0]) begin
                rs1_sel = reg_nibbles[i*4 +: 4];
            end
            if (rs2 == i[`TQV_REG_ADDR_BITS-1:0]) begin
                rs2_sel = reg_nibbles[i*4 +: 4];
            end
        end
    end

    assign rs1_data = rs1_sel;
    assign rs2_data = rs2_sel;

endmodule

// ==== core/tinyqv_register.sv ====
`timescale 1ns/10ps

module tinyqv_register (
    input  logic       clk,
    input  logic       wen,
    input  logic [3:0] data_in,
    output logic [3:0] data_out
);

    logic [31:0] value;

    // Rotates right by a nibble every cycle, so nibble k sits at the
    // bottom when the round counter is k
    always_ff @(posedge clk) begin
        value <= {wen ? data_in : value[3:0], value[31:4]};
    end

    assign data_out = value[3:0];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the tinyqv testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_tinyqv -f verilog.f -o sim_tinyqv \
    && ./obj_dir/sim_tinyqv > sim.log 2>&1 \
    || echo "Build or simulation exited with an error"

cat sim.log 2>/dev/null
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0

// ==== verif/tb_tinyqv.sv ====
`timescale 1ns/10ps

module tb_tinyqv;
    import tinyqv_pkg::*;

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic [31:0] instr;
        logic        is_store;
        mem_width_t  width;
        logic [27:0] addr;
        logic [31:0] data;
    } step_t;

    logic        clk = 1'b0;
    logic        rstn = 1'b0;
    logic        instr_fetch_started = 1'b0;
    logic        instr_fetch_stopped = 1'b0;
    logic [15:0] instr_data_in = 16'h0000;
    logic        instr_ready = 1'b0;
    logic        data_ready = 1'b0;
    logic [23:1] instr_addr;
    logic        instr_fetch_restart;
    logic        instr_fetch_stall;
    logic [27:0] data_addr;
    mem_width_t  data_write_n;
    logic [31:0] data_out;
    logic        debug_instr_complete;

    step_t       steps[$];         // Program table with expected stores
    step_t       stores_seen[$];
    step_t       captured;
    logic [15:0] prog_mem[$];
    int          complete_count = 0;
    int          store_count = 0;

    logic        fetch_on = 1'b0;
    int          fetch_addr = 0;   // Halfword index of the next delivery
    logic [31:0] fetch_rng = 32'h5146;
    int          data_state = 0;   // 0 idle, 1 delaying ack, 2 waiting for release
    int          ack_delay = 0;
    int          ack_wait = 0;
    logic [31:0] data_rng = 32'h5146;

    tinyqv_cpu i_tinyqv_cpu (
        .clk                  (clk),
        .rstn                 (rstn),
        .instr_addr           (instr_addr),
        .instr_fetch_restart  (instr_fetch_restart),
        .instr_fetch_stall    (instr_fetch_stall),
        .instr_fetch_started  (instr_fetch_started),
        .instr_fetch_stopped  (instr_fetch_stopped),
        .instr_data_in        (instr_data_in),
        .instr_ready          (instr_ready),
        .data_addr            (data_addr),
        .data_write_n         (data_write_n),
        .data_out             (data_out),
        .data_ready           (data_ready),
        .debug_instr_complete (debug_instr_complete)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] width_mask(input mem_width_t width);
        case (width)
            MEM_BYTE: return 32'h000000FF;
            MEM_HALF: return 32'h0000FFFF;
            default:  return 32'hFFFFFFFF;
        endcase
    endfunction

    // RISC-V base formats
    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic check_width(input string name, input mem_width_t actual,
                               input mem_width_t expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=%b expected=%b", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s actual=%b expected=%b", $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic add_op(input logic [31:0] word);
        step_t s;
        s = '0;
        s.instr = word;
        s.width = MEM_NONE;
        steps.push_back(s);
    endtask

    // Store of rs2 to offset(x1)
    task automatic add_store(input mem_width_t width, input logic [4:0] rs2,
                             input logic [11:0] offset, input logic [27:0] addr,
                             input logic [31:0] data);
        step_t s;
        s.instr    = {offset[11:5], rs2, 5'd1, {1'b0, width}, offset[4:0], 7'b0100011};
        s.is_store = 1'b1;
        s.width    = width;
        s.addr     = addr;
        s.data     = data;
        steps.push_back(s);
    endtask

    task automatic build_program();
        add_op(encode_u(20'h00012, 5'd1));                       // x1 = 0x00012000
        add_op(encode_i(12'h123, 5'd0, 3'b000, 5'd2));
        add_store(MEM_WORD, 5'd2, 12'h000, 28'h0012000, 32'h00000123);
        add_op(encode_i(12'hFFF, 5'd2, 3'b000, 5'd3));           // Negative immediate
        add_store(MEM_WORD, 5'd3, 12'h004, 28'h0012004, 32'h00000122);
        add_op(encode_i(12'hFFB, 5'd0, 3'b000, 5'd4));
        add_store(MEM_WORD, 5'd4, 12'h008, 28'h0012008, 32'hFFFFFFFB);
        add_op(encode_i(12'h0F0, 5'd4, 3'b111, 5'd5));           // ANDI
        add_op(encode_i(12'hF00, 5'd2, 3'b110, 5'd6));           // ORI
        add_op(encode_i(12'h7FF, 5'd4, 3'b100, 5'd7));           // XORI
        add_store(MEM_WORD, 5'd5, 12'h00C, 28'h001200C, 32'h000000F0);
        add_store(MEM_WORD, 5'd6, 12'h010, 28'h0012010, 32'hFFFFFF23);
        add_store(MEM_WORD, 5'd7, 12'h014, 28'h0012014, 32'hFFFFF804);
        add_op(encode_i(12'hFFC, 5'd4, 3'b010, 5'd8));           // -5 < -4
        add_op(encode_i(12'h100, 5'd2, 3'b010, 5'd9));
        add_store(MEM_WORD, 5'd8, 12'h018, 28'h0012018, 32'h00000001);
        add_store(MEM_WORD, 5'd9, 12'h01C, 28'h001201C, 32'h00000000);
        add_op(encode_u(20'h7FFFF, 5'd10));
        add_op(encode_i(12'h7FF, 5'd10, 3'b000, 5'd10));
        add_op(encode_r(7'h00, 5'd10, 5'd10, 3'b000, 5'd11));   // Carry ripples up
        add_store(MEM_WORD, 5'd11, 12'h020, 28'h0012020, 32'hFFFFEFFE);
        add_op(encode_r(7'h20, 5'd4, 5'd2, 3'b000, 5'd12));
        add_store(MEM_WORD, 5'd12, 12'h024, 28'h0012024, 32'h00000128);
        add_op(encode_r(7'h20, 5'd2, 5'd4, 3'b000, 5'd13));
        add_store(MEM_WORD, 5'd13, 12'h028, 28'h0012028, 32'hFFFFFED8);
        add_op(encode_r(7'h00, 5'd7, 5'd6, 3'b111, 5'd14));
        add_store(MEM_WORD, 5'd14, 12'h02C, 28'h001202C, 32'hFFFFF800);
        add_op(encode_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd15));
        add_store(MEM_WORD, 5'd15, 12'h030, 28'h0012030, 32'h000001F3);
        add_op(encode_r(7'h00, 5'd7, 5'd6, 3'b100, 5'd3));
        add_store(MEM_WORD, 5'd3, 12'h034, 28'h0012034, 32'h00000727);
        add_op(encode_r(7'h00, 5'd11, 5'd10, 3'b010, 5'd8));    // Overflowing compare
        add_op(encode_r(7'h00, 5'd10, 5'd11, 3'b010, 5'd9));
        add_store(MEM_WORD, 5'd8, 12'h038, 28'h0012038, 32'h00000000);
        add_store(MEM_WORD, 5'd9, 12'h03C, 28'h001203C, 32'h00000001);
        add_op(encode_i(12'h055, 5'd0, 3'b000, 5'd0));
        add_store(MEM_WORD, 5'd0, 12'h040, 28'h0012040, 32'h00000000);
        add_op(32'h0000016F);                                    // Unsupported JAL x2
        add_op(encode_i(12'h004, 5'd2, 3'b001, 5'd2));           // Unsupported SLLI
        add_store(MEM_WORD, 5'd2, 12'h044, 28'h0012044, 32'h00000123);
        add_store(MEM_BYTE, 5'd6, 12'h048, 28'h0012048, 32'hFFFFFF23);
        add_store(MEM_HALF, 5'd13, 12'h04A, 28'h001204A, 32'hFFFFFED8);
        add_store(MEM_WORD, 5'd12, 12'hFFC, 28'h0011FFC, 32'h00000128);
        foreach (steps[i]) begin
            prog_mem.push_back(steps[i].instr[15:0]);
            prog_mem.push_back(steps[i].instr[31:16]);
        end
    endtask

    // Instruction memory delivers sequential halfwords with random gaps
    always @(posedge clk) begin
        if (!rstn) begin
            instr_fetch_started <= 1'b0;
            instr_ready         <= 1'b0;
        end else if (!fetch_on) begin
            if (instr_fetch_restart) begin
                instr_fetch_started <= 1'b1;
                fetch_on = 1'b1;
                fetch_addr = int'(instr_addr);
            end
        end else begin
            instr_fetch_started <= 1'b0;
            if (!instr_ready) begin
                check_word("instr_addr", {9'd0, instr_addr}, fetch_addr);
            end
            fetch_rng = xorshift(fetch_rng);
            if (!instr_fetch_stall && fetch_addr < prog_mem.size() && fetch_rng[1:0] != 2'b00) begin
                instr_data_in <= prog_mem[fetch_addr];
                instr_ready   <= 1'b1;
                fetch_addr = fetch_addr + 1;
            end else begin
                instr_ready <= 1'b0;
            end
        end
    end

    // Data bus captures each write and acknowledges it after 0 to 20 cycles
    always @(posedge clk) begin
        if (!rstn) begin
            data_ready <= 1'b0;
        end else if (data_state == 0) begin
            if (data_write_n !== MEM_NONE) begin
                captured.width = data_write_n;
                captured.addr  = data_addr;
                captured.data  = data_out;
                stores_seen.push_back(captured);
                store_count = store_count + 1;
                data_rng = xorshift(data_rng);
                ack_delay = int'(data_rng % 21);
                data_state = 1;
            end
        end else if (data_state == 1) begin
            check_width("data_write_n", data_write_n, captured.width);
            check_word("data_addr", {4'h0, data_addr}, {4'h0, captured.addr});
            check_word("data_out", data_out, captured.data);
            if (ack_delay == 0) begin
                data_ready <= 1'b1;
                ack_wait = 0;
                data_state = 2;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end else begin
            data_ready <= 1'b0;
            ack_wait = ack_wait + 1;
            if (data_write_n === MEM_NONE) begin
                data_state = 0;
            end else if (ack_wait > TIMEOUT) begin
                $display("Timeout: data_write_n did not return to NONE after data_ready");
                stop_on_error();
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && debug_instr_complete === 1'b1) begin
            complete_count <= complete_count + 1;
        end
    end

    initial begin
        int    n_stores;
        int    waited;
        step_t got;
        logic [31:0] mask;

        build_program();
        repeat (16) @(posedge clk);
        check_width("data_write_n", data_write_n, MEM_NONE);
        check_bit("instr_fetch_stall", instr_fetch_stall, 1'b0);
        check_bit("instr_fetch_restart", instr_fetch_restart, 1'b1);
        check_word("instr_addr", {9'd0, instr_addr}, 32'h0);
        check_bit("debug_instr_complete", debug_instr_complete, 1'b0);
        rstn <= 1'b1;

        n_stores = 0;
        foreach (steps[i]) begin
            if (steps[i].is_store) begin
                waited = 0;
                while (stores_seen.size() == 0) begin
                    @(posedge clk);
                    waited = waited + 1;
                    if (waited > TIMEOUT) begin
                        $display("Timeout: no store seen for table entry %0d", i);
                        stop_on_error();
                    end
                end
                got  = stores_seen.pop_front();
                mask = width_mask(steps[i].width);
                check_width("data_write_n", got.width, steps[i].width);
                check_word("data_addr", {4'h0, got.addr}, {4'h0, steps[i].addr});
                check_word("data_out", got.data & mask, steps[i].data & mask);
                n_stores = n_stores + 1;
            end
        end

        waited = 0;
        while (complete_count < steps.size()) begin
            @(posedge clk);
            waited = waited + 1;
            if (waited > TIMEOUT) begin
                $display("Timeout: only %0d instructions retired", complete_count);
                stop_on_error();
            end
        end
        check_word("debug_instr_complete count", complete_count, steps.size());
        check_word("store count", store_count, n_stores);
        if (stores_seen.size() != 0) begin
            $display("An unexpected extra store appeared on the data bus");
            stop_on_error();
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/tinyqv_pkg.sv
verilog/tinyqv_decoder.sv
verilog/tinyqv_alu.sv
core/tinyqv_register.sv
core/tinyqv_reg_read.sv
core/tinyqv_core.sv
verilog/tinyqv_cpu.sv
verif/tb_tinyqv.sv

// ==== verilog/tinyqv_alu.sv ====
`timescale 1ns/10ps

module tinyqv_alu (
    input  logic                clk,
    input  tinyqv_pkg::alu_op_t op,
    input  logic [3:0]          a,
    input  logic [3:0]          b,
    input  logic [2:0]          counter,
    output logic [3:0]          result
);
    import tinyqv_pkg::*;

    logic       is_sub;
    logic [3:0] b_in;
    logic       carry_in;
    logic [4:0] sum;
    logic       carry;
    logic       lt;

    assign is_sub   = (op == ALU_SUB) || (op == ALU_SLT);
    assign b_in     = is_sub ? ~b : b;
    assign carry_in = (counter == 3'd0) ? is_sub : carry;  // +1 completes two's complement
    assign sum      = {1'b0, a} + {1'b0, b_in} + {4'b0000, carry_in};

    always_ff @(posedge clk) begin
        carry <= sum[4];
        // Top nibble gives the sign of the difference corrected for overflow
        if (counter == 3'd7) begin
            lt <= sum[3] ^ ((a[3] == b_in[3]) && (sum[3] != a[3]));
        end
    end

    always_comb begin
        case (op)
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = (counter == 3'd0) ? {3'b000, lt} : 4'h0;
            default: result = sum[3:0];
        endcase
    end

endmodule

// ==== verilog/tinyqv_cpu.sv ====
`timescale 1ns/10ps
`include "tinyqv_config.svh"

module tinyqv_cpu (
    input  logic                   clk,
    input  logic                   rstn,
    output logic [23:1]            instr_addr,
    output logic                   instr_fetch_restart,
    output logic                   instr_fetch_stall,
    input  logic                   instr_fetch_started,
    input  logic                   instr_fetch_stopped,
    input  logic [15:0]            instr_data_in,
    input  logic                   instr_ready,
    output logic [27:0]            data_addr,
    output tinyqv_pkg::mem_width_t data_write_n,
    output logic [31:0]            data_out,
    input  logic                   data_ready,
    output logic                   debug_instr_complete
);
    import tinyqv_pkg::*;

    // Fetch buffer
    logic [15:0] instr_data [0:3];
    logic [23:3] instr_data_start;    // Aligned base of the buffer window
    logic [2:1]  pc_offset;           // Next halfword to decode
    logic [3:1]  instr_write_offset;
    logic        instr_fetch_running;
    logic [3:1]  instr_avail;
    logic [3:1]  next_pc_offset;
    logic [2:1]  pc_offset_hi;
    logic [2:1]  pc_offset_nxt;
    logic [3:1]  write_offset_nxt;
    logic        pc_wrap;

    // Decoder outputs
    logic [31:0] instr;
    logic [31:0] imm_de;
    logic        is_alu_imm_de;
    logic        is_alu_reg_de;
    logic        is_lui_de;
    logic        is_store_de;
    alu_op_t     alu_op_de;
    mem_width_t  mem_width_de;
    logic [`TQV_REG_ADDR_BITS-1:0] rs1_de;
    logic [`TQV_REG_ADDR_BITS-1:0] rs2_de;
    logic [`TQV_REG_ADDR_BITS-1:0] rd_de;

    // Decode register
    logic [31:0] imm;
    logic        is_alu_imm;
    logic        is_alu_reg;
    logic        is_lui;
    logic        is_store;
    alu_op_t     alu_op;
    mem_width_t  mem_width;
    logic [`TQV_REG_ADDR_BITS-1:0] rs1;
    logic [`TQV_REG_ADDR_BITS-1:0] rs2;
    logic [`TQV_REG_ADDR_BITS-1:0] rd;
    logic        instr_valid;

    logic [2:0]  counter_hi;
    logic [4:0]  counter;             // Bit position of the current nibble
    logic        round_free;
    logic        take_instr;
    logic        no_write_in_progress;
    logic        stall_core;
    logic        instr_complete;
    logic [3:0]  data_out_slice;
    logic [27:0] addr_out;
    logic        address_ready;

    assign counter = {counter_hi, 2'b00};

    tinyqv_decoder i_decoder (
        .instr      (instr),
        .imm        (imm_de),
        .is_alu_imm (is_alu_imm_de),
        .is_alu_reg (is_alu_reg_de),
        .is_lui     (is_lui_de),
        .is_store   (is_store_de),
        .alu_op     (alu_op_de),
        .mem_width  (mem_width_de),
        .rs1        (rs1_de),
        .rs2        (rs2_de),
        .rd         (rd_de)
    );

    assign pc_offset_hi = pc_offset + 2'd1;
    assign instr        = {instr_data[pc_offset_hi], instr_data[pc_offset]};
    assign instr_avail  = instr_write_offset - {1'b0, pc_offset};

    // Decode register frees up at a round boundary once its instruction retires
    assign round_free = (counter_hi == 3'd7) && (!instr_valid || instr_complete);
    assign take_instr = round_free && (instr_avail >= 3'd2);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            instr_valid <= 1'b0;
            is_alu_imm  <= 1'b0;
            is_alu_reg  <= 1'b0;
            is_lui      <= 1'b0;
            is_store    <= 1'b0;
        end else if (round_free) begin
            instr_valid <= take_instr;
            is_alu_imm  <= is_alu_imm_de;
            is_alu_reg  <= is_alu_reg_de;
            is_lui      <= is_lui_de;
            is_store    <= is_store_de;
        end
    end

    always_ff @(posedge clk) begin
        if (take_instr) begin
            imm       <= imm_de;
            alu_op    <= alu_op_de;
            mem_width <= mem_width_de;
            rs1       <= rs1_de;
            rs2       <= rs2_de;
            rd        <= rd_de;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter_hi <= 3'd0;
        end else begin
            counter_hi <= counter_hi + 3'd1;
        end
    end

    // Hold a store until the previous write has been acknowledged
    assign stall_core = !instr_valid || (is_store && !no_write_in_progress);

    tinyqv_core i_core (
        .clk            (clk),
        .rstn           (rstn),
        .imm            (imm[counter +: 4]),
        .is_alu_imm     (is_alu_imm),
        .is_alu_reg     (is_alu_reg),
        .is_lui         (is_lui),
        .is_store       (is_store),
        .is_stall       (stall_core),
        .alu_op         (alu_op),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .counter        (counter_hi),
        .data_out       (data_out_slice),
        .addr_out       (addr_out),
        .address_ready  (address_ready),
        .instr_complete (instr_complete)
    );

    always_ff @(posedge clk) begin
        if (address_ready) begin
            data_addr <= addr_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_write_n         <= MEM_NONE;
            no_write_in_progress <= 1'b1;
        end else if (address_ready) begin
            data_write_n         <= mem_width;
            no_write_in_progress <= 1'b0;
        end else if (data_ready) begin
            data_write_n <= MEM_NONE;
            if (counter_hi == 3'd7) begin
                no_write_in_progress <= 1'b1;
            end
        end else if (counter_hi == 3'd7) begin
            no_write_in_progress <= (data_write_n == MEM_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (is_store && !stall_core) begin
            data_out[counter +: 4] <= data_out_slice;
        end
    end

    // Instruction fetch
    assign next_pc_offset   = {1'b0, pc_offset} + 3'd2;
    assign pc_wrap          = take_instr && next_pc_offset[3];
    assign pc_offset_nxt    = take_instr ? next_pc_offset[2:1] : pc_offset;
    assign write_offset_nxt = instr_write_offset
                            + {2'b00, instr_ready && instr_fetch_running}
                            - (pc_wrap ? 3'd4 : 3'd0);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            instr_data_start    <= '0;
            pc_offset           <= 2'd0;
            instr_write_offset  <= 3'd0;
            instr_fetch_running <= 1'b0;
        end else begin
            if (instr_fetch_started) begin
                instr_fetch_running <= 1'b1;
            end else if (instr_fetch_stopped) begin
                instr_fetch_running <= 1'b0;
            end
            instr_write_offset <= write_offset_nxt;
            pc_offset          <= pc_offset_nxt;
            if (pc_wrap) begin
                instr_data_start <= instr_data_start + 21'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_ready && instr_fetch_running) begin
            instr_data[instr_write_offset[2:1]] <= instr_data_in;
        end
    end

    // Full once four halfwords will be waiting after this edge
    assign instr_fetch_stall   = (write_offset_nxt - {1'b0, pc_offset_nxt}) == 3'd4;
    assign instr_fetch_restart = !instr_fetch_running;
    assign instr_addr          = {instr_data_start, 2'b00} + {20'd0, instr_write_offset};

    assign debug_instr_complete = instr_complete;

endmodule

// ==== verilog/tinyqv_decoder.sv ====
`timescale 1ns/10ps
`include "tinyqv_config.svh"

module tinyqv_decoder (
    input  logic [31:0]                   instr,
    output logic [31:0]                   imm,
    output logic                          is_alu_imm,
    output logic                          is_alu_reg,
    output logic                          is_lui,
    output logic                          is_store,
    output tinyqv_pkg::alu_op_t           alu_op,
    output tinyqv_pkg::mem_width_t        mem_width,
    output logic [`TQV_REG_ADDR_BITS-1:0] rs1,
    output logic [`TQV_REG_ADDR_BITS-1:0] rs2,
    output logic [`TQV_REG_ADDR_BITS-1:0] rd
);
    import tinyqv_pkg::*;

    opcode_t     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    alu_op_t     f3_op;
    logic        f3_ok;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Upper index bits ignored so x16 and up alias the low registers
    assign rd  = instr[7 +: `TQV_REG_ADDR_BITS];
    assign rs1 = instr[15 +: `TQV_REG_ADDR_BITS];
    assign rs2 = instr[20 +: `TQV_REG_ADDR_BITS];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'h000};

    // OP and OP-IMM share this funct3 map
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;   // Shifts and unsigned compares
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        is_alu_imm = 1'b0;
        is_alu_reg = 1'b0;
        is_lui     = 1'b0;
        is_store   = 1'b0;
        alu_op     = f3_op;
        mem_width  = MEM_NONE;
        imm        = imm_i;
        case (opcode)
            OPC_OP_IMM: is_alu_imm = f3_ok;
            OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    is_alu_reg = f3_ok;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    is_alu_reg = 1'b1;
                    alu_op     = ALU_SUB;
                end
            end
            OPC_LUI: begin
                is_lui = 1'b1;
                imm    = imm_u;
            end
            OPC_STORE: begin
                alu_op = ALU_ADD;  // rs1 + offset
                imm    = imm_s;
                if (!funct3[2] && funct3[1:0] != 2'b11) begin
                    is_store  = 1'b1;
                    mem_width = mem_width_t'(funct3[1:0]);
                end
            end
            default: ;  // Anything else retires with no effect
        endcase
    end

endmodule
